/* Bender.yml */
package:
  name: frame_loopback

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/frame_pkg.sv
      - logic/frame_config.sv
      - logic/pattern_stacker.sv
      - logic/chunk_unstacker.sv
      - logic/pixel_expander.sv
      - logic/frame_loopback_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/frame_loopback_checker.sv
      - testbench/tb_frame_loopback.sv

/* flist.f */
+incdir+logic
logic/frame_pkg.sv
logic/frame_config.sv
logic/pattern_stacker.sv
logic/chunk_unstacker.sv
logic/pixel_expander.sv
logic/frame_loopback_top.sv
testbench/frame_loopback_checker.sv
testbench/tb_frame_loopback.sv

/* logic/chunk_unstacker.sv */
// one-chunk buffer that replays its eight pixels in order, sits between stacker and expander
`timescale 1ns/1ps
`include "frame_macros.svh"

module chunk_unstacker (
  input  logic              clk_camera,
  input  logic              recent_reset,
  input  logic              chunk_valid_i,
  input  frame_pkg::chunk_t chunk_data_i,
  input  logic              chunk_last_i,
  input  logic              pixel_ready_i,
  output logic              chunk_ready_o,
  output logic              pixel_valid_o,
  output frame_pkg::pixel_t pixel_data_o,
  output logic              pixel_last_o
);

  import frame_pkg::*;

  localparam int SW = $clog2(`PIX_PER_CHUNK);

  // buffer holds a chunk, slot counter tracks position
  logic                    full_q;
  logic [SW-1:0]           slot_q;
  logic [`CHUNK_WIDTH-1:0] buf_q;
  // chunk was the last of its frame
  logic                    last_q;

  logic take;
  logic end_slot;

  assign take     = full_q && pixel_ready_i;
  assign end_slot = (slot_q == SW'(`PIX_PER_CHUNK - 1));

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      full_q <= 1'b0;
      slot_q <= '0;
    end else if (!full_q) begin
      // only fill when empty
      if (chunk_valid_i) begin
        full_q <= 1'b1;
        slot_q <= '0;
      end
    end else if (take) begin
      slot_q <= slot_q + 1'b1;
      // drained after slot 7
      if (end_slot) begin
        full_q <= 1'b0;
      end
    end
  end

  // shift right one pixel per take, current slot always in the low bits
  always_ff @(posedge clk_camera) begin
    if (!full_q) begin
      buf_q  <= chunk_data_i;
      last_q <= chunk_last_i;
    end else if (take) begin
      buf_q <= {{`PIX_WIDTH{1'b0}}, buf_q[`CHUNK_WIDTH-1:`PIX_WIDTH]};
    end
  end

  assign chunk_ready_o = !full_q;
  assign pixel_valid_o = full_q;
  assign pixel_data_o  = pixel_t'(buf_q[`PIX_WIDTH-1:0]);
  // frame last only on slot 7 of the marked chunk
  assign pixel_last_o  = full_q && last_q && end_slot;

endmodule

/* logic/frame_config.sv */
// pattern select register and frame counter, steers pattern_stacker between frames
`timescale 1ns/1ps

module frame_config (
  input  logic                    clk_camera,
  input  logic                    recent_reset,
  input  frame_pkg::pattern_t     pattern_sel_i,
  input  logic                    frame_done_i,
  output frame_pkg::pattern_t     pattern_o,
  output frame_pkg::frame_count_t frame_count_o
);

  import frame_pkg::*;

  // active pattern, never changes inside a frame
  pattern_t     pattern_q;
  // frames finished since reset
  frame_count_t count_q;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      // follow the switches while held in reset
      pattern_q <= pattern_sel_i;
      count_q   <= '0;
    end else if (frame_done_i) begin
      // last chunk just left, next frame takes the new code
      pattern_q <= pattern_sel_i;
      // wraps at 64 on its own
      count_q   <= count_q + 1'b1;
    end
  end

  assign pattern_o     = pattern_q;
  assign frame_count_o = count_q;

endmodule

/* logic/frame_loopback_top.sv */
// top of the pattern loopback, pattern source through chunk buffer to the rgb888 output
`timescale 1ns/1ps

module frame_loopback_top (
  input  logic                    clk_camera,
  input  logic                    recent_reset,
  input  frame_pkg::pattern_t     pattern_sel_i,
  input  logic                    draw_ready_i,
  output frame_pkg::color8_t      red_o,
  output frame_pkg::color8_t      green_o,
  output frame_pkg::color8_t      blue_o,
  output logic                    pixel_take_o,
  output logic                    pixel_last_o,
  output frame_pkg::frame_count_t frame_count_o
);

  import frame_pkg::*;

  // config to stacker
  pattern_t pattern;
  logic     frame_done;

  // chunk bus
  logic        chunk_valid;
  logic        chunk_ready;
  chunk_t      chunk_data;
  chunk_addr_t chunk_addr;
  logic        chunk_last;

  // pixel bus
  logic   pixel_valid;
  pixel_t pixel_data;
  logic   pixel_last;

  frame_config u_config (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .pattern_sel_i (pattern_sel_i),
    .frame_done_i  (frame_done),
    .pattern_o     (pattern),
    .frame_count_o (frame_count_o)
  );

  pattern_stacker u_stacker (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .pattern_i     (pattern),
    .chunk_ready_i (chunk_ready),
    .chunk_valid_o (chunk_valid),
    .chunk_data_o  (chunk_data),
    .chunk_addr_o  (chunk_addr),
    .chunk_last_o  (chunk_last),
    .frame_done_o  (frame_done)
  );

  chunk_unstacker u_unstacker (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .chunk_valid_i (chunk_valid),
    .chunk_data_i  (chunk_data),
    .chunk_last_i  (chunk_last),
    // display ready is a plain level
    .pixel_ready_i (draw_ready_i),
    .chunk_ready_o (chunk_ready),
    .pixel_valid_o (pixel_valid),
    .pixel_data_o  (pixel_data),
    .pixel_last_o  (pixel_last)
  );

  pixel_expander u_expander (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .pixel_valid_i (pixel_valid),
    .pixel_ready_i (draw_ready_i),
    .pixel_data_i  (pixel_data),
    .pixel_last_i  (pixel_last),
    .red_o         (red_o),
    .green_o       (green_o),
    .blue_o        (blue_o),
    .pixel_take_o  (pixel_take_o),
    .pixel_last_o  (pixel_last_o)
  );

endmodule

/* logic/frame_macros.svh */
// frame, chunk and color sizes for the pattern loopback, include where a width is needed
`ifndef FRAME_MACROS_SVH
`define FRAME_MACROS_SVH

// frame size in pixels
`define FB_HRES 320
`define FB_VRES 180

// one chunk carries eight rgb565 pixels
`define PIX_PER_CHUNK 8
`define PIX_WIDTH 16
`define CHUNK_WIDTH 128

// 320 * 180 / 8 chunks per frame
`define FRAME_CHUNKS 7200
`define ADDR_WIDTH 13

// rgb565 field widths, red on top
`define RED_WIDTH 5
`define GREEN_WIDTH 6
`define BLUE_WIDTH 5

// expanded channel width on the display side
`define COLOR_WIDTH 8

// pattern select code width
`define PAT_WIDTH 2

// shown whenever no pixel is taken
`define FILL_PIXEL 16'hf800

// frame counter, wraps at 64
`define FC_WIDTH 6

`endif

/* logic/frame_pkg.sv */
// shared types for the pattern loopback path, imported by the RTL and the testbench
`include "frame_macros.svh"

package frame_pkg;

  // one rgb565 word, read either raw or by color field
  typedef union packed {
    logic [`PIX_WIDTH-1:0] raw;
    struct packed {
      logic [`RED_WIDTH-1:0]   red;
      logic [`GREEN_WIDTH-1:0] green;
      logic [`BLUE_WIDTH-1:0]  blue;
    } rgb;
  } pixel_t;

  // eight pixels, slot 0 in the low bits
  typedef pixel_t [`PIX_PER_CHUNK-1:0] chunk_t;

  // chunk index within a frame
  typedef logic [`ADDR_WIDTH-1:0] chunk_addr_t;

  // 0 white, 1 column ramp, 2 row ramp, 3 checkerboard
  typedef logic [`PAT_WIDTH-1:0] pattern_t;

  // completed frames since reset
  typedef logic [`FC_WIDTH-1:0] frame_count_t;

  // one expanded display channel
  typedef logic [`COLOR_WIDTH-1:0] color8_t;

endpackage

/* logic/pattern_stacker.sv */
// test pattern source, walks the frame and hands out eight-pixel chunks with their address
`timescale 1ns/1ps
`include "frame_macros.svh"

module pattern_stacker (
  input  logic                   clk_camera,
  input  logic                   recent_reset,
  input  frame_pkg::pattern_t    pattern_i,
  input  logic                   chunk_ready_i,
  output logic                   chunk_valid_o,
  output frame_pkg::chunk_t      chunk_data_o,
  output frame_pkg::chunk_addr_t chunk_addr_o,
  output logic                   chunk_last_o,
  output logic                   frame_done_o
);

  import frame_pkg::*;

  localparam int HW = $clog2(`FB_HRES);
  localparam int VW = $clog2(`FB_VRES);

  // raster position of slot 0 in the current chunk
  logic [HW-1:0] h_q;
  logic [VW-1:0] v_q;
  chunk_addr_t   addr_q;

  logic   valid_q;
  chunk_t chunk_q;

  // combinational chunk for the current position
  chunk_t        chunk_next;
  pixel_t        pix;
  logic [HW-1:0] col;

  logic xfer;

  always_comb begin
    chunk_next = '0;
    pix        = '0;
    col        = '0;
    for (int i = 0; i < `PIX_PER_CHUNK; i++) begin
      col     = h_q + HW'(i);
      pix.raw = '0;
      unique case (pattern_i)
        2'd0: pix.raw = 16'hffff;
        // ramps write the counters straight into the raw word
        2'd1: pix.raw = `PIX_WIDTH'(col);
        2'd2: pix.raw = `PIX_WIDTH'(v_q);
        // checkerboard of 8x8 tiles, built through the fields
        2'd3: begin
          if (col[3] != v_q[3]) begin
            pix.rgb.red  = '1;
            pix.rgb.blue = '0;
          end else begin
            pix.rgb.red  = '0;
            pix.rgb.blue = '1;
          end
          pix.rgb.green = '0;
        end
        default: pix.raw = '0;
      endcase
      chunk_next[i] = pix;
    end
  end

  // transfer cycle on the chunk bus
  assign xfer = valid_q && chunk_ready_i;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      valid_q <= 1'b0;
      h_q     <= '0;
      v_q     <= '0;
      addr_q  <= '0;
    end else if (!valid_q) begin
      // load and present one cycle later
      valid_q <= 1'b1;
    end else if (xfer) begin
      valid_q <= 1'b0;
      // step eight columns, then next row
      if (h_q == HW'(`FB_HRES - `PIX_PER_CHUNK)) begin
        h_q <= '0;
        if (v_q == VW'(`FB_VRES - 1)) begin
          v_q <= '0;
        end else begin
          v_q <= v_q + 1'b1;
        end
      end else begin
        h_q <= h_q + HW'(`PIX_PER_CHUNK);
      end
      if (chunk_last_o) begin
        addr_q <= '0;
      end else begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

  // payload captured while idle, held through back-pressure
  always_ff @(posedge clk_camera) begin
    if (!valid_q) begin
      chunk_q <= chunk_next;
    end
  end

  assign chunk_valid_o = valid_q;
  assign chunk_data_o  = chunk_q;
  assign chunk_addr_o  = addr_q;
  assign chunk_last_o  = (addr_q == chunk_addr_t'(`FRAME_CHUNKS - 1));
  // one pulse as the last chunk of the frame leaves
  assign frame_done_o  = xfer && chunk_last_o;

endmodule

/* logic/pixel_expander.sv */
// display stage, registers rgb888 from each taken rgb565 pixel and fill red otherwise
`timescale 1ns/1ps
`include "frame_macros.svh"

module pixel_expander (
  input  logic              clk_camera,
  input  logic              recent_reset,
  input  logic              pixel_valid_i,
  input  logic              pixel_ready_i,
  input  frame_pkg::pixel_t pixel_data_i,
  input  logic              pixel_last_i,
  output frame_pkg::color8_t red_o,
  output frame_pkg::color8_t green_o,
  output frame_pkg::color8_t blue_o,
  output logic              pixel_take_o,
  output logic              pixel_last_o
);

  import frame_pkg::*;

  logic   take;
  pixel_t pix_sel;
  pixel_t fill;

  assign fill = pixel_t'(`FILL_PIXEL);
  // handshake on the pixel bus
  assign take = pixel_valid_i && pixel_ready_i;
  // no take shows fill red
  assign pix_sel = take ? pixel_data_i : fill;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pixel_take_o <= 1'b0;
      pixel_last_o <= 1'b0;
      // screen starts on fill red
      red_o   <= {fill.rgb.red, {(`COLOR_WIDTH - `RED_WIDTH){1'b0}}};
      green_o <= {fill.rgb.green, {(`COLOR_WIDTH - `GREEN_WIDTH){1'b0}}};
      blue_o  <= {fill.rgb.blue, {(`COLOR_WIDTH - `BLUE_WIDTH){1'b0}}};
    end else begin
      pixel_take_o <= take;
      pixel_last_o <= take && pixel_last_i;
      // zero pad each field up to 8 bits
      red_o   <= {pix_sel.rgb.red, {(`COLOR_WIDTH - `RED_WIDTH){1'b0}}};
      green_o <= {pix_sel.rgb.green, {(`COLOR_WIDTH - `GREEN_WIDTH){1'b0}}};
      blue_o  <= {pix_sel.rgb.blue, {(`COLOR_WIDTH - `BLUE_WIDTH){1'b0}}};
    end
  end

endmodule

/* testbench/frame_loopback_checker.sv */
// handshake assertions for frame_loopback_top, attached to every instance by bind
`timescale 1ns/1ps

module frame_loopback_checker (
  input logic                   clk_camera,
  input logic                   recent_reset,
  input logic                   chunk_valid_i,
  input logic                   chunk_ready_i,
  input frame_pkg::chunk_t      chunk_data_i,
  input frame_pkg::chunk_addr_t chunk_addr_i,
  input logic                   pixel_take_i,
  input logic                   pixel_last_i
);

  import frame_pkg::*;

  // stalled chunk keeps valid, payload and address
  property chunk_held;
    @(posedge clk_camera) disable iff (recent_reset)
      chunk_valid_i && !chunk_ready_i |=>
        chunk_valid_i && $stable(chunk_data_i) && $stable(chunk_addr_i);
  endproperty

  // expander output is idle right after a reset cycle
  property take_idle_after_reset;
    @(posedge clk_camera) recent_reset |=> !pixel_take_i;
  endproperty

  // frame last only rides on a delivered pixel
  property last_with_take;
    @(posedge clk_camera) disable iff (recent_reset)
      pixel_last_i |-> pixel_take_i;
  endproperty

  a_chunk_held: assert property (chunk_held)
    else $error("chunk payload changed while the unstacker was stalled");
  a_take_idle: assert property (take_idle_after_reset)
    else $error("pixel_take_o high in the cycle after reset");
  a_last_take: assert property (last_with_take)
    else $error("pixel_last_o high without pixel_take_o");

endmodule

bind frame_loopback_top frame_loopback_checker u_checker (
  .clk_camera    (clk_camera),
  .recent_reset  (recent_reset),
  .chunk_valid_i (chunk_valid),
  .chunk_ready_i (chunk_ready),
  .chunk_data_i  (chunk_data),
  .chunk_addr_i  (chunk_addr),
  .pixel_take_i  (pixel_take_o),
  .pixel_last_i  (pixel_last_o)
);

/* testbench/tb_frame_loopback.sv */
// testbench for frame_loopback_top, random draw ready checked against a raster pattern model
`timescale 1ns/1ps
`include "frame_macros.svh"

module tb_frame_loopback;

  import frame_pkg::*;

  localparam int FRAME_PIXELS = `FB_HRES * `FB_VRES;
  // about 15 cycles per chunk at 60 % ready, so plenty of margin
  localparam int FRAME_CYCLES = 250000;

  logic         clk_camera;
  logic         recent_reset;
  pattern_t     pattern_sel_i;
  logic         draw_ready_i;
  color8_t      red_o;
  color8_t      green_o;
  color8_t      blue_o;
  logic         pixel_take_o;
  logic         pixel_last_o;
  frame_count_t frame_count_o;

  int errors;
  int tests_run;
  int tests_failed;

  frame_loopback_top uut (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .pattern_sel_i (pattern_sel_i),
    .draw_ready_i  (draw_ready_i),
    .red_o         (red_o),
    .green_o       (green_o),
    .blue_o        (blue_o),
    .pixel_take_o  (pixel_take_o),
    .pixel_last_o  (pixel_last_o),
    .frame_count_o (frame_count_o)
  );

  initial begin
    clk_camera = 1'b0;
    forever #5 clk_camera = ~clk_camera;
  end

  // display ready about 60 % of cycles
  function automatic logic random_ready();
    return ($urandom % 100) < 60;
  endfunction

  // expected rgb565 word at column h, row v
  function automatic logic [15:0] pattern_word(input pattern_t pat, input int h, input int v);
    logic [15:0] word;
    word = 16'h0000;
    case (pat)
      2'd0: word = 16'hffff;
      2'd1: word = 16'(h);
      2'd2: word = 16'(v);
      default: begin
        // 8x8 tiles, full red where the tile bits differ, else full blue
        if (h[3] != v[3]) begin
          word = {5'd31, 6'd0, 5'd0};
        end else begin
          word = {5'd0, 6'd0, 5'd31};
        end
      end
    endcase
    return word;
  endfunction

  task automatic check_color(input string name, input color8_t got, input color8_t exp);
    if (got !== exp) begin
      errors++;
      $display("error: %s got 0x%02h expected 0x%02h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_count(input string name, input frame_count_t got,
                             input frame_count_t exp);
    if (got !== exp) begin
      errors++;
      $display("error: %s got 0x%02h expected 0x%02h at %0t", name, got, exp, $time);
    end
  endtask

  // fields shifted up and zero padded to 8 bits
  task automatic check_rgb(input logic [15:0] word);
    check_color("red_o", red_o, {word[15:11], 3'b000});
    check_color("green_o", green_o, {word[10:5], 2'b00});
    check_color("blue_o", blue_o, {word[4:0], 3'b000});
  endtask

  // one clock, then on to the drive point
  task automatic next_cycle();
    @(posedge clk_camera);
    #1;
  endtask

  task automatic apply_reset(input pattern_t pat);
    recent_reset  = 1'b1;
    pattern_sel_i = pat;
    repeat (10) begin
      next_cycle();
      draw_ready_i = random_ready();
    end
    recent_reset = 1'b0;
  endtask

  // outputs as left by the last reset edge
  task automatic expect_reset_state();
    check_flag("pixel_take_o", pixel_take_o, 1'b0);
    check_flag("pixel_last_o", pixel_last_o, 1'b0);
    check_count("frame_count_o", frame_count_o, '0);
    check_rgb(`FILL_PIXEL);
  endtask

  // follow delivered pixels through whole frames, plus the first pixel after them
  task automatic play_frames(input int frames, input pattern_t switch_pat, input int switch_idx);
    pattern_t    cur_pat;
    pattern_t    next_pat;
    logic [15:0] word;
    logic        stop;
    int          idx;
    int          done;
    int          cycles;
    int          limit;
    cur_pat  = pattern_sel_i;
    next_pat = pattern_sel_i;
    stop     = 1'b0;
    idx      = 0;
    done     = 0;
    cycles   = 0;
    limit    = (frames + 1) * FRAME_CYCLES;
    while (!stop && cycles < limit) begin
      next_cycle();
      cycles++;
      if (pixel_take_o) begin
        word = pattern_word(cur_pat, idx % `FB_HRES, idx / `FB_HRES);
        check_rgb(word);
        check_flag("pixel_last_o", pixel_last_o, idx == FRAME_PIXELS - 1);
        if (idx == 0) begin
          // counter moved when the last chunk left, well before this pixel
          check_count("frame_count_o", frame_count_o, frame_count_t'(done));
          stop = (done == frames);
        end
        if (idx == FRAME_PIXELS - 1) begin
          idx = 0;
          done++;
          // selection seen at the frame boundary
          cur_pat = next_pat;
        end else begin
          idx++;
        end
        if (done == 0 && idx == switch_idx) begin
          pattern_sel_i = switch_pat;
          next_pat      = switch_pat;
        end
      end else begin
        check_rgb(`FILL_PIXEL);
        check_flag("pixel_last_o", pixel_last_o, 1'b0);
      end
      draw_ready_i = random_ready();
    end
    if (!stop) begin
      errors++;
      $display("timeout: frame %0d did not complete within %0d cycles", done, limit);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  initial begin
    int mark;
    recent_reset  = 1'b1;
    pattern_sel_i = '0;
    draw_ready_i  = 1'b0;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    void'($urandom(32'h22be_6c38));

    mark = errors;
    apply_reset(2'd0);
    expect_reset_state();
    report_test("reset_state", mark);

    // one frame per code, fill and frame count checked on the way
    for (int p = 0; p < 4; p++) begin
      mark = errors;
      apply_reset(pattern_t'(p));
      expect_reset_state();
      play_frames(1, pattern_t'(p), -1);
      report_test($sformatf("pattern_%0d", p), mark);
    end

    // column ramp, checkerboard requested halfway through the first frame
    mark = errors;
    apply_reset(2'd1);
    expect_reset_state();
    play_frames(2, 2'd3, FRAME_PIXELS / 2);
    report_test("pattern_switch", mark);

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
